/* source/cnn_pkg.sv */
package cnn_pkg;

    // Bit positions in the host control word
    typedef enum logic [2:0] {
        cnn_start      = 3'd0,
        cnn_reset      = 3'd1,
        pixel_valid    = 3'd2,
        frame_start    = 3'd3,
        frame_complete = 3'd4
    } ctrl_bit_e;

    // Sticky error code seen by the host
    typedef enum logic [31:0] {
        error_none          = 32'd0,
        error_cnn_timeout   = 32'd1,   // No pixel for too long inside a frame
        error_invalid_start = 32'd2    // Frame start while a frame is open
    } error_code_e;

    // Status word bit positions with bits 31:5 reading as zero
    localparam int STATUS_BUSY           = 0;
    localparam int STATUS_RESULT_VALID   = 1;
    localparam int STATUS_PIXEL_VALID    = 2;
    localparam int STATUS_FRAME_START    = 3;
    localparam int STATUS_FRAME_COMPLETE = 4;

    // Fixed 1-D edge kernel  -1  2  -1
    localparam logic signed [3:0] KERNEL_W0 = -4'sd1;
    localparam logic signed [3:0] KERNEL_W1 = 4'sd2;
    localparam logic signed [3:0] KERNEL_W2 = -4'sd1;

    localparam int PIXEL_W   = 8;
    localparam int FEATURE_W = 10;   // Largest ReLU output is 2*255
    localparam int SCORE_W   = 20;

    // Conv window fill level
    typedef enum logic [1:0] {
        empty,
        one_tap,
        two_tap,
        full
    } conv_state_e;

    // Pooling pair tracking
    typedef enum logic [1:0] {
        idle,        // No frame open
        wait_pair,   // Next feature starts a pair
        have_first   // First feature of the pair held
    } pool_state_e;

endpackage

/* source/pixel_stream_if.sv */
interface pixel_stream_if #(
    parameter int DATA_W = cnn_pkg::PIXEL_W
);

    logic              start;     // First item of a frame follows
    logic              valid;     // data carries an item this cycle
    logic [DATA_W-1:0] data;
    logic              complete;  // Frame closed by the host
    logic              abort;     // Drop the running frame

    modport sender (
        output start,
        output valid,
        output data,
        output complete,
        output abort
    );

    modport receiver (
        input start,
        input valid,
        input data,
        input complete,
        input abort
    );

endinterface

/* source/host_control.sv */
module host_control #(
    parameter int TIMEOUT_CYCLES = 64
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [31:0]           control_reg,
    input  logic [31:0]           pixel_reg,
    input  logic                  result_valid,
    pixel_stream_if.sender        pix_bus,
    output logic [31:0]           status_reg,
    output logic [31:0]           frame_count_reg,
    output logic [31:0]           error_code_reg
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [31:0]               ctrl_q;       // Control word of the last cycle
    logic [31:0]               ctrl_rise;
    logic                      start_req;
    logic                      reset_req;
    logic                      pix_req;
    logic                      done_req;
    logic                      start_ok;
    logic                      timeout;
    logic                      busy;
    logic [CNT_W-1:0]          idle_cnt;
    logic [31:0]               frame_cnt;
    cnn_pkg::error_code_e      err_q;

    assign ctrl_rise = control_reg & ~ctrl_q;

    // cnn_start and frame_start open a frame the same way
    assign start_req = ctrl_rise[cnn_pkg::cnn_start] | ctrl_rise[cnn_pkg::frame_start];
    assign reset_req = ctrl_rise[cnn_pkg::cnn_reset];
    assign pix_req   = ctrl_rise[cnn_pkg::pixel_valid];
    assign done_req  = ctrl_rise[cnn_pkg::frame_complete];

    assign start_ok = start_req & ~busy & ~reset_req;
    assign timeout  = busy & ~pix_req & (idle_cnt == CNT_W'(TIMEOUT_CYCLES - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q           <= '0;
            pix_bus.start    <= 1'b0;
            pix_bus.valid    <= 1'b0;
            pix_bus.complete <= 1'b0;
            pix_bus.abort    <= 1'b0;
        end else begin
            ctrl_q           <= control_reg;
            pix_bus.start    <= start_ok;
            pix_bus.valid    <= pix_req & busy;    // Pixels outside a frame are dropped
            pix_bus.complete <= done_req & busy;
            pix_bus.abort    <= reset_req | timeout;
        end
    end

    // Pixel byte rides with the valid strobe
    always_ff @(posedge clk) begin
        if (pix_req) begin
            pix_bus.data <= pixel_reg[cnn_pkg::PIXEL_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            idle_cnt <= '0;
        end else begin
            if (start_ok) begin
                busy <= 1'b1;
            end else if (reset_req || timeout || result_valid) begin
                busy <= 1'b0;
            end

            // Counts cycles without a pixel inside an open frame
            if (!busy || pix_req || timeout) begin
                idle_cnt <= '0;
            end else begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q     <= cnn_pkg::error_none;
            frame_cnt <= '0;
        end else begin
            if (reset_req) begin
                err_q <= cnn_pkg::error_none;
            end else if (timeout) begin
                err_q <= cnn_pkg::error_cnn_timeout;
            end else if (start_req && busy) begin
                err_q <= cnn_pkg::error_invalid_start;
            end

            if (result_valid) begin
                frame_cnt <= frame_cnt + 32'd1;
            end
        end
    end

    always_comb begin
        status_reg = '0;
        status_reg[cnn_pkg::STATUS_BUSY]           = busy;
        status_reg[cnn_pkg::STATUS_RESULT_VALID]   = result_valid;
        status_reg[cnn_pkg::STATUS_PIXEL_VALID]    = pix_bus.valid;
        status_reg[cnn_pkg::STATUS_FRAME_START]    = pix_bus.start;
        status_reg[cnn_pkg::STATUS_FRAME_COMPLETE] = pix_bus.complete;
    end

    assign frame_count_reg = frame_cnt;
    assign error_code_reg  = err_q;

    // A start only leaves an idle engine and opens the frame
    a_no_start_while_busy : assert property (
        @(posedge clk) disable iff (!rst_n) pix_bus.start |-> $rose(busy)
    );

endmodule

/* source/conv_stage.sv */
module conv_stage (
    input  logic             clk,
    input  logic             rst_n,
    pixel_stream_if.receiver pix_bus,
    pixel_stream_if.sender   feat_bus
);

    localparam int ACC_W = cnn_pkg::FEATURE_W + 2;   // Signed range is -510 to 510

    cnn_pkg::conv_state_e          conv_state;
    logic [cnn_pkg::PIXEL_W-1:0]   tap_mid;    // Previous pixel
    logic [cnn_pkg::PIXEL_W-1:0]   tap_old;    // Pixel before that
    logic signed [ACC_W-1:0]       acc;
    logic [cnn_pkg::FEATURE_W-1:0] relu;
    logic                          window_ok;

    // Middle tap carries the positive weight
    always_comb begin
        acc = cnn_pkg::KERNEL_W0 * $signed({1'b0, tap_old})
            + cnn_pkg::KERNEL_W1 * $signed({1'b0, tap_mid})
            + cnn_pkg::KERNEL_W2 * $signed({1'b0, pix_bus.data});
        relu = acc[ACC_W-1] ? '0 : acc[cnn_pkg::FEATURE_W-1:0];
    end

    // Two held pixels plus the incoming one form a window
    assign window_ok = (conv_state == cnn_pkg::two_tap) || (conv_state == cnn_pkg::full);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_state <= cnn_pkg::empty;
        end else if (pix_bus.start || pix_bus.abort) begin
            conv_state <= cnn_pkg::empty;       // New frame never sees old pixels
        end else if (pix_bus.valid) begin
            case (conv_state)
                cnn_pkg::empty:   conv_state <= cnn_pkg::one_tap;
                cnn_pkg::one_tap: conv_state <= cnn_pkg::two_tap;
                default:          conv_state <= cnn_pkg::full;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pix_bus.valid) begin
            tap_old <= tap_mid;
            tap_mid <= pix_bus.data;
        end
    end

    // Frame strobes follow the same one-cycle delay as the features
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            feat_bus.start    <= 1'b0;
            feat_bus.valid    <= 1'b0;
            feat_bus.complete <= 1'b0;
            feat_bus.abort    <= 1'b0;
        end else begin
            feat_bus.start    <= pix_bus.start;
            feat_bus.valid    <= pix_bus.valid & window_ok & ~pix_bus.start & ~pix_bus.abort;
            feat_bus.complete <= pix_bus.complete;
            feat_bus.abort    <= pix_bus.abort;
        end
    end

    always_ff @(posedge clk) begin
        if (pix_bus.valid && window_ok) begin
            feat_bus.data <= relu;
        end
    end

    // A feature needs three pixels of the current frame
    a_no_feature_when_empty : assert property (
        @(posedge clk) disable iff (!rst_n) feat_bus.valid |-> conv_state != cnn_pkg::empty
    );

endmodule

/* source/pool_stage.sv */
module pool_stage (
    input  logic                        clk,
    input  logic                        rst_n,
    pixel_stream_if.receiver            feat_bus,
    output logic                        result_valid,
    output logic [cnn_pkg::SCORE_W-1:0] result_score
);

    cnn_pkg::pool_state_e          state_q;
    cnn_pkg::pool_state_e          state_next;
    logic [cnn_pkg::FEATURE_W-1:0] first_q;     // Held first feature of a pair
    logic [cnn_pkg::FEATURE_W-1:0] first_next;
    logic [cnn_pkg::FEATURE_W-1:0] pair_max;
    logic [cnn_pkg::SCORE_W-1:0]   score_q;
    logic [cnn_pkg::SCORE_W-1:0]   score_next;
    logic [cnn_pkg::SCORE_W-1:0]   final_score;

    assign pair_max = (first_q > feat_bus.data) ? first_q : feat_bus.data;

    // Next pair state counting a feature that lands with complete
    always_comb begin
        state_next = state_q;
        first_next = first_q;
        score_next = score_q;
        if (feat_bus.valid) begin
            case (state_q)
                cnn_pkg::wait_pair: begin
                    first_next = feat_bus.data;
                    state_next = cnn_pkg::have_first;
                end
                cnn_pkg::have_first: begin
                    score_next = score_q + cnn_pkg::SCORE_W'(pair_max);
                    state_next = cnn_pkg::wait_pair;
                end
                default: ;   // No frame open
            endcase
        end
        // Odd last feature counts alone
        final_score = score_next;
        if (state_next == cnn_pkg::have_first) begin
            final_score = score_next + cnn_pkg::SCORE_W'(first_next);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= cnn_pkg::idle;
            score_q      <= '0;
            result_valid <= 1'b0;
            result_score <= '0;
        end else begin
            result_valid <= 1'b0;
            if (feat_bus.abort) begin
                state_q <= cnn_pkg::idle;
                score_q <= '0;
            end else if (feat_bus.start) begin
                state_q <= cnn_pkg::wait_pair;
                score_q <= '0;
            end else if (feat_bus.complete && state_q != cnn_pkg::idle) begin
                result_valid <= 1'b1;
                result_score <= final_score;
                state_q      <= cnn_pkg::idle;
                score_q      <= '0;
            end else begin
                state_q <= state_next;
                score_q <= score_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        first_q <= first_next;
    end

    // One strobe per frame
    a_result_one_cycle : assert property (
        @(posedge clk) disable iff (!rst_n) result_valid |=> !result_valid
    );

endmodule

/* source/cnn_top.sv */
module cnn_top #(
    parameter int TIMEOUT_CYCLES = 64   // Idle cycles inside a frame before abort
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [31:0]                 control_reg,
    input  logic [31:0]                 pixel_reg,
    output logic [31:0]                 status_reg,
    output logic [31:0]                 frame_count_reg,
    output logic [31:0]                 error_code_reg,
    output logic                        result_valid,
    output logic [cnn_pkg::SCORE_W-1:0] result_score
);

    // Raw pixels from the host
    pixel_stream_if #(
        .DATA_W (cnn_pkg::PIXEL_W)
    ) pix_bus ();

    // ReLU features into the pooling stage
    pixel_stream_if #(
        .DATA_W (cnn_pkg::FEATURE_W)
    ) feat_bus ();

    host_control #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) host_control_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .control_reg     (control_reg),
        .pixel_reg       (pixel_reg),
        .result_valid    (result_valid),   // Ends the frame and bumps the counter
        .pix_bus         (pix_bus.sender),
        .status_reg      (status_reg),
        .frame_count_reg (frame_count_reg),
        .error_code_reg  (error_code_reg)
    );

    conv_stage conv_stage_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_bus  (pix_bus.receiver),
        .feat_bus (feat_bus.sender)
    );

    // Score lands 3 cycles after the frame_complete bit is sampled
    pool_stage pool_stage_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .feat_bus     (feat_bus.receiver),
        .result_valid (result_valid),
        .result_score (result_score)
    );

endmodule

/* sim/tb_cnn_top.sv */
module tb_cnn_top;

    localparam int TIMEOUT_CYCLES = 64;
    localparam int WAIT_LIMIT     = 8;    // Cycles watched for a result after complete

    logic        clk;
    logic        rst_n;
    logic [31:0] control_reg;
    logic [31:0] pixel_reg;
    logic [31:0] status_reg;
    logic [31:0] frame_count_reg;
    logic [31:0] error_code_reg;
    logic        result_valid;
    logic [19:0] result_score;

    integer seed = 32'hb0d6_5c83;
    int     error_count = 0;
    int     check_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    int     result_count = 0;      // result_valid strobes seen so far
    bit     result_window = 1'b0;  // A result may arrive now
    bit     limit_ready = 1'b0;

    // Command kinds from the data file are 0 frame, 1 reset and 2 idle
    int cmd_kind[$];
    int cmd_mode[$];
    int cmd_gap[$];
    int cmd_len[$];
    int cmd_score[$];
    int cmd_err[$];
    int pixels[$];   // Pixels of all frames back to back

    cnn_top #(
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) cnn_top_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .control_reg     (control_reg),
        .pixel_reg       (pixel_reg),
        .status_reg      (status_reg),
        .frame_count_reg (frame_count_reg),
        .error_code_reg  (error_code_reg),
        .result_valid    (result_valid),
        .result_score    (result_score)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (limit_ready && cycle_count > cycle_limit);
        $display("Timeout: the test did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $finish;
    end

    task automatic check_cond(input bit cond, input string msg);
        check_count++;
        assert (cond) else begin
            $display("Error at time %0t: %s", $time, msg);
            error_count++;
        end
    endtask

    // Expected score straight from the kernel and pooling rules
    function automatic int frame_score(input int first, input int n);
        int feat[$];
        int score;
        int f;
        score = 0;
        for (int i = 2; i < n; i++) begin
            f = 2 * pixels[first + i - 1] - pixels[first + i - 2] - pixels[first + i];
            feat.push_back((f < 0) ? 0 : f);
        end
        for (int i = 0; i < feat.size(); i += 2) begin
            if (i + 1 < feat.size()) begin
                score += (feat[i] > feat[i + 1]) ? feat[i] : feat[i + 1];
            end else begin
                score += feat[i];   // Odd last feature
            end
        end
        return score;
    endfunction

    // One cycle that ends on the falling edge where outputs are stable
    task automatic step();
        @(negedge clk);
        check_cond(frame_count_reg == result_count,
            $sformatf("frame_count_reg is %0d, expected %0d", frame_count_reg, result_count));
        check_cond(status_reg[31:5] == '0, "reserved status bits are not zero");
        if (result_valid) begin
            result_count++;
            check_cond(result_window, "result_valid without a closing frame");
        end
    endtask

    task automatic pulse_bit(input int pos);
        control_reg[pos] = 1'b1;
        step();
        control_reg[pos] = 1'b0;
    endtask

    task automatic load_commands(input int fd);
        logic [63:0]      word;
        logic [8*160-1:0] rest;
        int               mode;
        int               gap;
        int               len;
        int               score;
        int               err;
        int               p;
        cycle_limit = 204;   // Reset plus margin
        while ($fscanf(fd, "%s", word) == 1) begin
            if (word == "#") begin
                void'($fgets(rest, fd));
            end else if (word == "frame") begin
                void'($fscanf(fd, "%d %d %d %d %d", mode, gap, len, score, err));
                cmd_kind.push_back(0);
                cmd_mode.push_back(mode);
                cmd_gap.push_back(gap);
                cmd_len.push_back(len);
                cmd_score.push_back(score);
                cmd_err.push_back(err);
                for (int i = 0; i < len; i++) begin
                    if (mode == 4) begin
                        p = $random(seed) & 255;
                    end else begin
                        void'($fscanf(fd, "%d", p));
                    end
                    pixels.push_back(p);
                end
                cycle_limit += 2 * len + gap + 16;
            end else if (word == "reset" || word == "idle") begin
                gap = 4;
                if (word == "idle") begin
                    void'($fscanf(fd, "%d", gap));
                end
                cmd_kind.push_back((word == "reset") ? 1 : 2);
                cmd_mode.push_back(0);
                cmd_gap.push_back(gap);
                cmd_len.push_back(0);
                cmd_score.push_back(0);
                cmd_err.push_back(0);
                cycle_limit += gap;
            end else begin
                $display("Unknown command in the data file, reading stopped");
                error_count++;
                break;
            end
        end
    endtask

    task automatic run_frame(input int c, input int first);
        int n;
        bit open;
        int wait_cycles;
        n    = cmd_len[c];
        open = 1'b1;
        check_cond(!status_reg[0], "busy already set before frame start");
        pulse_bit(cnn_pkg::frame_start);
        check_cond(status_reg[0] && status_reg[3], "frame start not seen in status_reg");
        step();
        for (int i = 0; i < n; i++) begin
            if (i == n / 2 && cmd_mode[c] == 1) begin
                pulse_bit(cnn_pkg::frame_start);   // Second start is dropped
                check_cond(error_code_reg == 2 && !status_reg[3],
                    $sformatf("error code %0d after start inside a frame", error_code_reg));
                step();
            end else if (i == n / 2 && cmd_mode[c] == 2) begin
                repeat (cmd_gap[c]) step();
                // One idle cycle already follows the last pixel
                open = (cmd_gap[c] + 1 < TIMEOUT_CYCLES);
                check_cond(status_reg[0] == open && (open || error_code_reg == 1),
                    "busy or error code wrong after idle gap");
            end else if (i == n / 2 && cmd_mode[c] == 3) begin
                pulse_bit(cnn_pkg::cnn_reset);
                open = 1'b0;
                check_cond(!status_reg[0] && error_code_reg == 0, "cnn_reset left frame open");
                step();
            end
            pixel_reg = pixels[first + i];
            pulse_bit(cnn_pkg::pixel_valid);
            check_cond(status_reg[2] == open && status_reg[0] == open,
                "pixel strobe or busy wrong in status_reg");
            step();
        end
        result_window = open;
        pulse_bit(cnn_pkg::frame_complete);
        check_cond(status_reg[4] == open, "frame complete strobe wrong in status_reg");
        wait_cycles = 1;
        while (!result_valid && wait_cycles < WAIT_LIMIT) begin
            step();
            wait_cycles++;
        end
        if (open) begin
            check_cond(result_valid && status_reg[1] && wait_cycles == 3,
                $sformatf("result_valid after %0d cycles, expected 3", wait_cycles));
            check_cond(result_score == frame_score(first, n),
                $sformatf("score %0d, model gives %0d", result_score, frame_score(first, n)));
            if (cmd_mode[c] != 4) begin
                check_cond(result_score == cmd_score[c],
                    $sformatf("score %0d, data file gives %0d", result_score, cmd_score[c]));
            end
        end
        result_window = 1'b0;
        step();
        check_cond(!status_reg[0] && error_code_reg == cmd_err[c],
            $sformatf("after frame busy %0b error code %0d, expected 0 and %0d",
                status_reg[0], error_code_reg, cmd_err[c]));
    endtask

    initial begin
        int fd;
        int first;
        control_reg = '0;
        pixel_reg   = '0;
        rst_n       = 1'b0;
        first       = 0;
        fd = $fopen("sim/cnn_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the data file sim/cnn_input.txt");
            $display("Simulation failed");
            $finish;
        end else begin
            load_commands(fd);
            $fclose(fd);
            limit_ready = 1'b1;
            repeat (2) @(negedge clk);
            rst_n = 1'b1;
            foreach (cmd_kind[c]) begin
                if (cmd_kind[c] == 0) begin
                    run_frame(c, first);
                    first += cmd_len[c];
                end else if (cmd_kind[c] == 1) begin
                    pulse_bit(cnn_pkg::cnn_reset);
                    check_cond(error_code_reg == 0 && !status_reg[0], "cnn_reset did not clear");
                    step();
                end else begin
                    repeat (cmd_gap[c]) step();
                end
            end
            $display("Checks: %0d, errors: %0d, results: %0d",
                check_count, error_count, result_count);
            if (error_count == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

endmodule

/* sim/cnn_input.txt */
# frame mode gap len score err pixels , mode 4 draws its pixels from the seed
# mode 0 plain , 1 second start , 2 idle gap , 3 reset inside , 4 random
# reset pulses cnn_reset , idle <cycles> waits between commands
frame 0 0 6 160 0   10 50 10 50 10 50
frame 0 0 3 510 0   0 255 0
frame 0 0 7 150 0   5 30 5 30 5 30 5
idle 6
# second frame start inside the frame
frame 1 0 5 200 2   200 100 200 100 200
frame 0 0 4 62 2    9 40 9 40
reset
# gap beyond the timeout aborts the frame
frame 2 80 6 -1 1   1 2 3 4 5 6
frame 2 20 4 126 1  7 70 7 70
reset
# reset in the middle of a frame
frame 3 0 6 -1 0    50 60 70 80 90 100
idle 10
frame 4 0 9 0 0
frame 4 0 12 0 0
frame 0 0 8 1530 0  255 0 255 0 255 0 255 0
idle 5

/* tb.f */
source/cnn_pkg.sv
source/pixel_stream_if.sv
source/host_control.sv
source/conv_stage.sv
source/pool_stage.sv
source/cnn_top.sv
sim/tb_cnn_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CNN engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f tb.f --top-module tb_cnn_top -o sim_cnn

out=$(./obj_dir/sim_cnn 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
    exit 0
fi
exit 1
